/* Makefile */
TOP := rapid_recovery_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) \
		-f rapid_recovery.f -o Vrapid_recovery_tb

run: compile
	./obj_dir/Vrapid_recovery_tb

clean:
	rm -rf obj_dir

/* rapid_recovery.f */
source/rapid_recovery_pkg.sv
source/rr_address_generator.sv
source/rr_recovery_ctrl.sv
source/rr_backup_regfile.sv
source/rr_backup_csr_pc.sv
source/rapid_recovery_top.sv
verif/rapid_recovery_tb.sv

/* source/rapid_recovery_pkg.sv */
`default_nettype none

package rapid_recovery_pkg;

  // Data path width of the core
  localparam int unsigned XLEN = 32;

  // Register file geometry
  // Full file address, 32 entries
  localparam int unsigned RfAddrWidth = 5;
  // Address inside one half of the file
  localparam int unsigned RfHalfAddrWidth = RfAddrWidth - 1;
  // Entries per half, also the offset of replay port b
  localparam int unsigned RfHalfDepth = 2 ** RfHalfAddrWidth;

  // Backed-up CSRs
  localparam int unsigned NumCsr = 4;
  localparam int unsigned CsrIdxWidth = $clog2(NumCsr);

  // Data word or program counter
  typedef logic [XLEN-1:0] word_t;

  // Register file address, full range
  typedef logic [RfAddrWidth-1:0] rf_addr_t;

  // Register file address, lower half only
  typedef logic [RfHalfAddrWidth-1:0] rf_half_addr_t;

  // Selects one of the backed-up CSRs
  typedef logic [CsrIdxWidth-1:0] csr_idx_t;

  // Recovery routine phases
  // IDLE     backup mirrors core state
  // RESET    backup frozen, setback issued next
  // HALT     waiting for the core to enter debug halt
  // RESTORE  saved state replayed over the recovery ports
  typedef enum logic [1:0] {
    IDLE,
    RESET,
    HALT,
    RESTORE
  } recovery_mode_e;

endpackage

`default_nettype wire

/* source/rapid_recovery_top.sv */
`default_nettype none

module rapid_recovery_top (
  input  logic                                                  clk_i,
  input  logic                                                  rst_ni,

  // Core register file writes
  input  logic                                                  core_rf_we_i,
  input  rapid_recovery_pkg::rf_addr_t                          core_rf_waddr_i,
  input  rapid_recovery_pkg::word_t                             core_rf_wdata_i,

  // Core PC and CSR updates
  input  logic                                                  core_pc_we_i,
  input  rapid_recovery_pkg::word_t                             core_pc_i,
  input  logic                                                  core_csr_we_i,
  input  rapid_recovery_pkg::csr_idx_t                          core_csr_idx_i,
  input  rapid_recovery_pkg::word_t                             core_csr_wdata_i,

  // Core status and fault detector
  input  logic                                                  debug_halt_i,
  input  logic                                                  start_recovery_i,

  // Core control
  output logic                                                  setback_o,
  output logic                                                  instr_lock_o,
  output logic                                                  debug_req_o,
  output logic                                                  debug_resume_o,

  // Recovery register file ports, shared write enable
  output logic                                                  rec_rf_we_o,
  output rapid_recovery_pkg::rf_addr_t                          rec_rf_waddr_a_o,
  output rapid_recovery_pkg::word_t                             rec_rf_wdata_a_o,
  output rapid_recovery_pkg::rf_addr_t                          rec_rf_waddr_b_o,
  output rapid_recovery_pkg::word_t                             rec_rf_wdata_b_o,

  // Recovery PC and CSRs
  output logic                                                  rec_pc_valid_o,
  output rapid_recovery_pkg::word_t                             rec_pc_o,
  output logic                                                  rec_csr_valid_o,
  output rapid_recovery_pkg::word_t [rapid_recovery_pkg::NumCsr-1:0] rec_csr_o,

  output logic                                                  recovery_finished_o
);

  import rapid_recovery_pkg::*;

  logic          backup_enable;
  logic          rf_restore_enable;
  logic          csr_pc_restore_enable;
  logic          addr_done;
  rf_half_addr_t rf_half_addr;

  rr_recovery_ctrl u_recovery_ctrl (
    .clk_i                   ( clk_i                 ),
    .rst_ni                  ( rst_ni                ),
    .start_recovery_i        ( start_recovery_i      ),
    .debug_halt_i            ( debug_halt_i          ),
    .addr_done_i             ( addr_done             ),
    .rf_half_addr_i          ( rf_half_addr          ),
    .recovery_finished_o     ( recovery_finished_o   ),
    .setback_o               ( setback_o             ),
    .instr_lock_o            ( instr_lock_o          ),
    .debug_req_o             ( debug_req_o           ),
    .debug_resume_o          ( debug_resume_o        ),
    .backup_enable_o         ( backup_enable         ),
    .csr_pc_restore_enable_o ( csr_pc_restore_enable ),
    .rf_restore_enable_o     ( rf_restore_enable     ),
    .rec_rf_we_o             ( rec_rf_we_o           ),
    .rec_rf_waddr_a_o        ( rec_rf_waddr_a_o      ),
    .rec_rf_waddr_b_o        ( rec_rf_waddr_b_o      )
  );

  // Walks the lower half during the RF restore
  rr_address_generator u_address_generator (
    .clk_i     ( clk_i             ),
    .rst_ni    ( rst_ni            ),
    .enable_i  ( rf_restore_enable ),
    .done_o    ( addr_done         ),
    .address_o ( rf_half_addr      )
  );

  // Read addresses are the recovery write addresses themselves
  rr_backup_regfile u_backup_regfile (
    .clk_i           ( clk_i            ),
    .rst_ni          ( rst_ni           ),
    .backup_enable_i ( backup_enable    ),
    .core_rf_we_i    ( core_rf_we_i     ),
    .core_rf_waddr_i ( core_rf_waddr_i  ),
    .core_rf_wdata_i ( core_rf_wdata_i  ),
    .raddr_a_i       ( rec_rf_waddr_a_o ),
    .raddr_b_i       ( rec_rf_waddr_b_o ),
    .rdata_a_o       ( rec_rf_wdata_a_o ),
    .rdata_b_o       ( rec_rf_wdata_b_o )
  );

  rr_backup_csr_pc u_backup_csr_pc (
    .clk_i            ( clk_i                 ),
    .rst_ni           ( rst_ni                ),
    .backup_enable_i  ( backup_enable         ),
    .restore_enable_i ( csr_pc_restore_enable ),
    .core_pc_we_i     ( core_pc_we_i          ),
    .core_pc_i        ( core_pc_i             ),
    .core_csr_we_i    ( core_csr_we_i         ),
    .core_csr_idx_i   ( core_csr_idx_i        ),
    .core_csr_wdata_i ( core_csr_wdata_i      ),
    .rec_pc_valid_o   ( rec_pc_valid_o        ),
    .rec_pc_o         ( rec_pc_o              ),
    .rec_csr_valid_o  ( rec_csr_valid_o       ),
    .rec_csr_o        ( rec_csr_o             )
  );

endmodule

`default_nettype wire

/* source/rr_address_generator.sv */
`default_nettype none

module rr_address_generator (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  // Advance once per cycle while high
  input  logic                              enable_i,
  // Counter sits on its final value
  output logic                              done_o,
  output rapid_recovery_pkg::rf_half_addr_t address_o
);

  import rapid_recovery_pkg::*;

  // Last half address of the walk
  localparam rf_half_addr_t LastAddr = rf_half_addr_t'(RfHalfDepth - 1);

  rf_half_addr_t cnt_d, cnt_q;

  // Next count
  always_comb begin
    cnt_d = cnt_q;
    if (enable_i) begin
      // Natural overflow wraps back to 0 after the last entry
      cnt_d = cnt_q + rf_half_addr_t'(1);
    end
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  assign address_o = cnt_q;

  // Done only depends on the count, so an enable that drops early
  // would leave the counter parked and done stuck high
  assign done_o = (cnt_q == LastAddr);

  // Enable must span the whole walk up to and including the last address
  a_done_needs_enable : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    done_o |-> enable_i
  ) else $error("address generator done without enable");

  // Counter is back at 0 whenever the walk is not running
  a_idle_at_zero : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !enable_i |-> (cnt_q == '0)
  ) else $error("address generator left mid-walk");

endmodule

`default_nettype wire

/* source/rr_backup_csr_pc.sv */
`default_nettype none

module rr_backup_csr_pc (
  input  logic                                                  clk_i,
  input  logic                                                  rst_ni,

  // Controller enables
  input  logic                                                  backup_enable_i,
  input  logic                                                  restore_enable_i,

  // Core PC update
  input  logic                                                  core_pc_we_i,
  input  rapid_recovery_pkg::word_t                             core_pc_i,

  // Core CSR write
  input  logic                                                  core_csr_we_i,
  input  rapid_recovery_pkg::csr_idx_t                          core_csr_idx_i,
  input  rapid_recovery_pkg::word_t                             core_csr_wdata_i,

  // Restore outputs
  output logic                                                  rec_pc_valid_o,
  output rapid_recovery_pkg::word_t                             rec_pc_o,
  output logic                                                  rec_csr_valid_o,
  output rapid_recovery_pkg::word_t [rapid_recovery_pkg::NumCsr-1:0] rec_csr_o
);

  import rapid_recovery_pkg::*;

  word_t              pc_q;
  word_t [NumCsr-1:0] csr_q;

  logic pc_capture;
  logic csr_capture;

  // Capture strobes gated by the mirror enable
  assign pc_capture  = core_pc_we_i && backup_enable_i;
  assign csr_capture = core_csr_we_i && backup_enable_i;

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      pc_q <= '0;
    end else if (pc_capture) begin
      pc_q <= core_pc_i;
    end
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      csr_q <= '0;
    end else if (csr_capture) begin
      csr_q[core_csr_idx_i] <= core_csr_wdata_i;
    end
  end

  // Saved values stay on the bus, valids mark the restore window
  assign rec_pc_valid_o  = restore_enable_i;
  assign rec_pc_o        = pc_q;
  assign rec_csr_valid_o = restore_enable_i;
  assign rec_csr_o       = csr_q;

  // Backup stays frozen for the whole replay
  a_no_capture_in_restore : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    restore_enable_i |-> !(pc_capture || csr_capture)
  ) else $error("PC or CSR captured during restore");

endmodule

`default_nettype wire

/* source/rr_backup_regfile.sv */
`default_nettype none

module rr_backup_regfile (
  input  logic                         clk_i,
  input  logic                         rst_ni,

  // Mirror enable from the controller
  input  logic                         backup_enable_i,

  // Core register file write port
  input  logic                         core_rf_we_i,
  input  rapid_recovery_pkg::rf_addr_t core_rf_waddr_i,
  input  rapid_recovery_pkg::word_t    core_rf_wdata_i,

  // Replay read ports
  input  rapid_recovery_pkg::rf_addr_t raddr_a_i,
  input  rapid_recovery_pkg::rf_addr_t raddr_b_i,
  output rapid_recovery_pkg::word_t    rdata_a_o,
  output rapid_recovery_pkg::word_t    rdata_b_o
);

  import rapid_recovery_pkg::*;

  // Shadow copy of all 32 entries
  word_t rf_q [2**RfAddrWidth];

  logic  capture;

  // Only mirror while the core state is trusted
  assign capture = core_rf_we_i && backup_enable_i;

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      for (int unsigned i = 0; i < 2**RfAddrWidth; i++) begin
        rf_q[i] <= '0;
      end
    end else if (capture) begin
      rf_q[core_rf_waddr_i] <= core_rf_wdata_i;
    end
  end

  // Combinational reads, data lines up with the write strobe
  assign rdata_a_o = rf_q[raddr_a_i];
  assign rdata_b_o = rf_q[raddr_b_i];

  // Replay pairs are always one half apart
  a_read_pair : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    raddr_b_i == raddr_a_i + rf_addr_t'(RfHalfDepth)
  ) else $error("replay read addresses not a half apart");

endmodule

`default_nettype wire

/* source/rr_recovery_ctrl.sv */
`default_nettype none

module rr_recovery_ctrl (
  input  logic                              clk_i,
  input  logic                              rst_ni,

  // Mismatch strobe from the fault detector
  input  logic                              start_recovery_i,
  // Core reports debug halt
  input  logic                              debug_halt_i,

  // From the address generator
  input  logic                              addr_done_i,
  input  rapid_recovery_pkg::rf_half_addr_t rf_half_addr_i,

  output logic                              recovery_finished_o,

  // Core control
  output logic                              setback_o,
  output logic                              instr_lock_o,
  output logic                              debug_req_o,
  output logic                              debug_resume_o,

  // Backup block control
  output logic                              backup_enable_o,
  output logic                              csr_pc_restore_enable_o,
  output logic                              rf_restore_enable_o,

  // Recovery register file write port, two addresses one strobe
  output logic                              rec_rf_we_o,
  output rapid_recovery_pkg::rf_addr_t      rec_rf_waddr_a_o,
  output rapid_recovery_pkg::rf_addr_t      rec_rf_waddr_b_o
);

  import rapid_recovery_pkg::*;

  recovery_mode_e rec_mode_d, rec_mode_q;

  logic setback_d, setback_q;
  logic instr_lock_d, instr_lock_q;

  always_comb begin
    // Defaults hold state and keep strobes low
    rec_mode_d              = rec_mode_q;
    instr_lock_d            = instr_lock_q;
    setback_d               = 1'b0;
    backup_enable_o         = 1'b0;
    debug_req_o             = 1'b0;
    debug_resume_o          = 1'b0;
    recovery_finished_o     = 1'b0;
    csr_pc_restore_enable_o = 1'b0;
    rf_restore_enable_o     = 1'b0;

    unique case (rec_mode_q)
      IDLE: begin
        // Mirror core writes
        backup_enable_o = 1'b1;
        if (start_recovery_i) begin
          // Freeze the backup in the same cycle the mismatch shows up
          backup_enable_o = 1'b0;
          rec_mode_d      = RESET;
        end
      end

      RESET: begin
        // Setback and lock both register here, visible in HALT
        setback_d    = 1'b1;
        instr_lock_d = 1'b1;
        rec_mode_d   = HALT;
      end

      HALT: begin
        // Hold the request until the core confirms
        debug_req_o = 1'b1;
        if (debug_halt_i) begin
          rec_mode_d = RESTORE;
        end
      end

      RESTORE: begin
        // Replay PC, CSRs and two RF entries per cycle
        csr_pc_restore_enable_o = 1'b1;
        rf_restore_enable_o     = 1'b1;
        if (addr_done_i) begin
          // Last pair written, hand control back to the core
          debug_resume_o      = 1'b1;
          recovery_finished_o = 1'b1;
          instr_lock_d        = 1'b0;
          rec_mode_d          = IDLE;
        end
      end

      default: begin
        rec_mode_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      rec_mode_q   <= IDLE;
      setback_q    <= 1'b0;
      instr_lock_q <= 1'b0;
    end else begin
      rec_mode_q   <= rec_mode_d;
      setback_q    <= setback_d;
      instr_lock_q <= instr_lock_d;
    end
  end

  assign setback_o    = setback_q;
  assign instr_lock_o = instr_lock_q;

  // Write port follows the RF restore phase
  assign rec_rf_we_o = rf_restore_enable_o;

  // Port a walks the lower half, port b the matching upper entry
  assign rec_rf_waddr_a_o = rf_addr_t'(rf_half_addr_i);
  assign rec_rf_waddr_b_o = rf_addr_t'(rf_half_addr_i) + rf_addr_t'(RfHalfDepth);

  // Backup must be frozen whenever a halt is being requested
  a_no_backup_in_halt : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !(backup_enable_o && debug_req_o)
  ) else $error("backup enabled during halt request");

  // Setback is a single-cycle pulse
  a_setback_pulse : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    setback_o |=> !setback_o
  ) else $error("setback longer than one cycle");

endmodule

`default_nettype wire

/* verif/rapid_recovery_tb.sv */
`default_nettype none

module rapid_recovery_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import rapid_recovery_pkg::*;

  localparam int unsigned NumRecoveries = 4;
  // Random write cycles before each recovery
  localparam int unsigned IdleCycles    = 150;
  // Per recovery 2 setup cycles, 16 restore cycles, up to 8 halt cycles
  localparam int unsigned TimeoutCycles = NumRecoveries * (2 + 16 + 8) + 600 + 100;
  localparam rf_half_addr_t LastIdx     = rf_half_addr_t'(RfHalfDepth - 1);

  logic clk_i, rst_ni;
  logic core_rf_we_i, core_pc_we_i, core_csr_we_i, debug_halt_i, start_recovery_i;
  rf_addr_t core_rf_waddr_i;
  word_t    core_rf_wdata_i, core_pc_i, core_csr_wdata_i;
  csr_idx_t core_csr_idx_i;

  logic setback_o, instr_lock_o, debug_req_o, debug_resume_o, recovery_finished_o;
  logic rec_rf_we_o, rec_pc_valid_o, rec_csr_valid_o;
  rf_addr_t rec_rf_waddr_a_o, rec_rf_waddr_b_o;
  word_t    rec_rf_wdata_a_o, rec_rf_wdata_b_o, rec_pc_o;
  word_t [NumCsr-1:0] rec_csr_o;

  // Reference model state
  recovery_mode_e     mode_q;
  rf_half_addr_t      idx_q;
  logic               first_halt_q;
  word_t              model_rf [2**RfAddrWidth];
  word_t              model_pc;
  word_t [NumCsr-1:0] model_csr;

  logic        exp_restore, exp_last;
  logic [7:0]  exp_ctrl, ctrl_bus;
  logic [15:0] lfsr_q;
  int unsigned cycle_cnt;

  rapid_recovery_top u_rapid_recovery_top (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  task automatic abort_run();
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string sig, input logic [127:0] exp_v,
                                 input logic [127:0] act_v);
    $display("FAILED at %0d ns: %s expected 0x%0h actual 0x%0h", $time, sig, exp_v, act_v);
    abort_run();
  endtask

  // Fibonacci LFSR, taps 16 14 13 11, one step per bit handed out
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] bits;
    logic        fb;
    bits = '0;
    for (int unsigned i = 0; i < n; i++) begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      bits   = {bits[30:0], fb};
    end
    return bits;
  endfunction

  // One clock of random core traffic, start strobe back low
  task automatic next_cycle();
    @(posedge clk_i);
    start_recovery_i <= 1'b0;
    core_rf_we_i     <= 1'(rand_bits(1));
    core_rf_waddr_i  <= rf_addr_t'(rand_bits(RfAddrWidth));
    core_rf_wdata_i  <= rand_bits(XLEN);
    core_pc_we_i     <= 1'(rand_bits(1));
    core_pc_i        <= rand_bits(XLEN);
    core_csr_we_i    <= 1'(rand_bits(1));
    core_csr_idx_i   <= csr_idx_t'(rand_bits(CsrIdxWidth));
    core_csr_wdata_i <= rand_bits(XLEN);
  endtask

  // Mismatch strobe, core halts after a random delay, extra starts on the way
  task automatic run_recovery();
    int unsigned halt_wait;
    int unsigned restore_cycles;
    next_cycle();
    start_recovery_i <= 1'b1;
    do begin
      next_cycle();
      @(negedge clk_i);
    end while (!debug_req_o);
    halt_wait = rand_bits(3);
    repeat (halt_wait) next_cycle();
    next_cycle();
    debug_halt_i     <= 1'b1;
    // Sampled in HALT, must be ignored
    start_recovery_i <= 1'b1;
    restore_cycles = 0;
    do begin
      next_cycle();
      // Another stray start in the middle of the replay
      if (restore_cycles == 4) begin
        start_recovery_i <= 1'b1;
      end
      restore_cycles++;
      @(negedge clk_i);
    end while (!recovery_finished_o);
    next_cycle();
    debug_halt_i <= 1'b0;
  endtask

  // Expected sequence, shadow state captured only in IDLE
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mode_q       <= IDLE;
      idx_q        <= '0;
      first_halt_q <= 1'b0;
      model_pc     <= '0;
      model_csr    <= '0;
      for (int unsigned i = 0; i < 2**RfAddrWidth; i++) begin
        model_rf[i] <= '0;
      end
    end else begin
      first_halt_q <= (mode_q == RESET);
      case (mode_q)
        IDLE: begin
          if (start_recovery_i) begin
            mode_q <= RESET;
          end else begin
            if (core_rf_we_i) model_rf[core_rf_waddr_i] <= core_rf_wdata_i;
            if (core_pc_we_i) model_pc <= core_pc_i;
            if (core_csr_we_i) model_csr[core_csr_idx_i] <= core_csr_wdata_i;
          end
        end
        RESET: mode_q <= HALT;
        HALT: begin
          if (debug_halt_i) begin
            mode_q <= RESTORE;
            idx_q  <= '0;
          end
        end
        default: begin
          idx_q <= idx_q + rf_half_addr_t'(1);
          if (idx_q == LastIdx) mode_q <= IDLE;
        end
      endcase
    end
  end

  assign exp_restore = (mode_q == RESTORE);
  assign exp_last    = exp_restore && (idx_q == LastIdx);
  // setback, lock, req, resume, we, pc valid, csr valid, finished
  assign ctrl_bus = {setback_o, instr_lock_o, debug_req_o, debug_resume_o,
                     rec_rf_we_o, rec_pc_valid_o, rec_csr_valid_o, recovery_finished_o};
  assign exp_ctrl = {first_halt_q, (mode_q == HALT) || exp_restore, mode_q == HALT,
                     exp_last, exp_restore, exp_restore, exp_restore, exp_last};

  // Control outputs every cycle, reset included
  a_controls : assert property (@(posedge clk_i) ctrl_bus == exp_ctrl)
    else report_mismatch("control outputs", 128'($sampled(exp_ctrl)), 128'($sampled(ctrl_bus)));

  a_waddr : assert property (@(posedge clk_i)
    exp_restore |-> {rec_rf_waddr_b_o, rec_rf_waddr_a_o} == {1'b1, idx_q, 1'b0, idx_q})
    else report_mismatch("rec_rf_waddr_b_o/a_o", 128'({1'b1, $sampled(idx_q), 1'b0,
      $sampled(idx_q)}), 128'({$sampled(rec_rf_waddr_b_o), $sampled(rec_rf_waddr_a_o)}));

  a_wdata_a : assert property (@(posedge clk_i)
    exp_restore |-> rec_rf_wdata_a_o == model_rf[{1'b0, idx_q}])
    else report_mismatch("rec_rf_wdata_a_o", 128'($sampled(model_rf[{1'b0, idx_q}])),
      128'($sampled(rec_rf_wdata_a_o)));

  a_wdata_b : assert property (@(posedge clk_i)
    exp_restore |-> rec_rf_wdata_b_o == model_rf[{1'b1, idx_q}])
    else report_mismatch("rec_rf_wdata_b_o", 128'($sampled(model_rf[{1'b1, idx_q}])),
      128'($sampled(rec_rf_wdata_b_o)));

  a_pc : assert property (@(posedge clk_i) exp_restore |-> rec_pc_o == model_pc)
    else report_mismatch("rec_pc_o", 128'($sampled(model_pc)), 128'($sampled(rec_pc_o)));

  a_csr : assert property (@(posedge clk_i) exp_restore |-> rec_csr_o == model_csr)
    else report_mismatch("rec_csr_o", $sampled(model_csr), $sampled(rec_csr_o));

  // Run length bound
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TimeoutCycles) begin
      $display("Timeout: run did not finish within %0d cycles", TimeoutCycles);
      abort_run();
    end
  end

  initial begin
    lfsr_q           = 16'd28;
    cycle_cnt        = 0;
    rst_ni           <= 1'b0;
    start_recovery_i <= 1'b0;
    debug_halt_i     <= 1'b0;
    core_rf_we_i     <= 1'b0;
    core_rf_waddr_i  <= '0;
    core_rf_wdata_i  <= '0;
    core_pc_we_i     <= 1'b0;
    core_pc_i        <= '0;
    core_csr_we_i    <= 1'b0;
    core_csr_idx_i   <= '0;
    core_csr_wdata_i <= '0;
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    for (int unsigned r = 0; r < NumRecoveries; r++) begin
      repeat (IdleCycles) next_cycle();
      run_recovery();
    end
    repeat (4) next_cycle();
    @(negedge clk_i);
    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire
